// ==== bench/flash_model.sv ====
`include "cpu_defines.svh"

module flash_model (
	input  logic cs_n,
	input  logic sclk,
	input  cpu_pkg::nibble_t dout,
	input  cpu_pkg::nibble_t oe_n,
	output cpu_pkg::nibble_t din
);
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	data_t image [256];
	addr_t log_q [$];   // Address of every read
	logic bus_error;
	int rises;          // SCLK rising edges since CS# fell
	addr_t addr;
	data_t rd_byte;

	initial begin
		din = '0;
		bus_error = 1'b0;
		rises = 0;
		addr = '0;
	end

	always @(posedge sclk or negedge cs_n) begin
		if (!sclk) begin
			rises = 0;   // CS# just fell, SCLK idles low
		end else if (!cs_n) begin
			rises = rises + 1;
			if (rises >= 3 && rises <= 6)
				addr = {addr[11:0], dout};
			if (rises == 6)
				log_q.push_back(addr);
			if ((rises <= 2 && dout !== 4'h0) || (rises == 7 && dout !== `QSPI_MODE_HI)
					|| (rises == 8 && dout !== `QSPI_MODE_LO))
				bus_error = 1'b1;
			if ((rises <= 8) ? (oe_n !== 4'b0000) : (oe_n !== 4'b1111))
				bus_error = 1'b1;
		end
	end

	// Data leaves on the falling edge after the fourth dummy clock
	always @(negedge sclk) begin
		if (!cs_n) begin
			rd_byte = image[addr[7:0]];
			if (rises == 12)
				din <= #2 rd_byte[7:4];
			else if (rises == 13)
				din <= #2 rd_byte[3:0];
		end
	end

endmodule

// ==== bench/ref_model.svh ====
data_t model_img [256];
data_t model_ram [`CPU_RAM_SIZE];
logic model_q;

// Flash reads are logged together with the Q value at that moment
function automatic data_t model_load(input addr_t a);
	if (a[15])
		return model_ram[a % `CPU_RAM_SIZE];
	exp_addr.push_back(a);
	exp_q.push_back(model_q);
	return model_img[a[7:0]];
endfunction

// Runs model_img until IDL and fills exp_addr, exp_q, exp_final_q and n_instr
function automatic void predict_trace(input nibble_t flags_n);
	addr_t r [16];
	data_t d;
	data_t m;
	data_t ins;
	logic df;
	logic cond;
	logic stop;
	reg_sel_t x;
	reg_sel_t p;
	reg_sel_t n;
	exp_addr.delete();
	exp_q.delete();
	foreach (r[i])
		r[i] = '0;
	foreach (model_ram[i])
		model_ram[i] = '0;
	d = '0;
	df = 1'b0;
	x = '0;
	p = '0;
	model_q = 1'b0;
	stop = 1'b0;
	n_instr = 0;
	while (!stop && n_instr < 2000) begin
		ins = model_load(r[p]);
		r[p] = r[p] + 16'd1;
		n = ins[3:0];
		n_instr++;
		case (ins[7:4])
			4'h0: begin
				if (n == 4'h0)
					stop = 1'b1;
				else
					d = model_load(r[n]);
			end
			4'h1: r[n] = r[n] + 16'd1;
			4'h2: r[n] = r[n] - 16'd1;
			4'h3: begin
				case (n[2:0])
					3'd0: cond = 1'b1;
					3'd1: cond = model_q;
					3'd2: cond = (d == 8'h00);
					3'd3: cond = df;
					default: cond = !flags_n[n[1:0]];   // Pins are active low
				endcase
				if (cond != n[3])
					r[p][7:0] = model_load(r[p]);
				else
					r[p] = r[p] + 16'd1;
			end
			4'h4: begin
				d = model_load(r[n]);
				r[n] = r[n] + 16'd1;
			end
			4'h5: begin
				if (r[n][15])
					model_ram[r[n] % `CPU_RAM_SIZE] = d;   // Flash writes are lost
			end
			4'h7: begin
				if (ins == 8'h7A) begin
					model_q = 1'b0;
				end else if (ins == 8'h7B) begin
					model_q = 1'b1;
				end else if (n == 4'h2) begin
					d = model_load(r[x]);
					r[x] = r[x] + 16'd1;
				end
			end
			4'h8: d = r[n][7:0];
			4'h9: d = r[n][15:8];
			4'hA: r[n][7:0] = d;
			4'hB: r[n][15:8] = d;
			4'hD: p = n;
			4'hE: x = n;
			4'hF: begin
				if (n == 4'h6) begin
					df = d[0];
					d = d >> 1;
				end else if (n == 4'hE) begin
					df = d[7];
					d = d << 1;
				end else begin
					if (n[3]) begin
						m = model_load(r[p]);
						r[p] = r[p] + 16'd1;
					end else begin
						m = model_load(r[x]);
					end
					case (n[2:0])
						3'd0: d = m;
						3'd1: d = d | m;
						3'd2: d = d & m;
						3'd3: d = d ^ m;
						3'd4: begin
							df = (int'(d) + int'(m)) > 255;
							d = d + m;
						end
						3'd5: begin
							df = (m >= d);   // No borrow
							d = m - d;
						end
						default: begin
							df = (d >= m);
							d = d - m;
						end
					endcase
				end
			end
			default: ;
		endcase
	end
	exp_final_q = model_q;
endfunction

// ==== bench/tb_top.sv ====
`include "cpu_defines.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	logic clk;
	logic rst_n;
	nibble_t ef_n;
	nibble_t rom_din;
	logic q;
	logic rom_cs_n;
	logic rom_sclk;
	nibble_t rom_dout;
	nibble_t rom_oe_n;

	addr_t exp_addr [$];   // Flash reads in order
	logic exp_q [$];       // Q at each of those reads
	logic exp_final_q;
	int n_instr;
	int cycle_cnt;
	int deadline;          // 0 while no program runs
	int seed;

	`include "ref_model.svh"

	cpu_top i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ef_n     (ef_n),
		.rom_din  (rom_din),
		.q        (q),
		.rom_cs_n (rom_cs_n),
		.rom_sclk (rom_sclk),
		.rom_dout (rom_dout),
		.rom_oe_n (rom_oe_n)
	);

	flash_model i_flash (
		.cs_n (rom_cs_n),
		.sclk (rom_sclk),
		.dout (rom_dout),
		.oe_n (rom_oe_n),
		.din  (rom_din)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_flash_bus(input string name);
		if (i_flash.bus_error)
			stop_with_failure({name, ": wrong mode bits or lane direction on the flash bus"});
	endtask

	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clk);
			cycle_cnt = cycle_cnt + 1;
			if (deadline > 0 && cycle_cnt > deadline)
				stop_with_failure("Timeout: the program did not reach IDL in time");
		end
	end

	task automatic run_program(input string name, input nibble_t flags_n);
		int i;
		predict_trace(flags_n);
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		ef_n = flags_n;   // Held for the whole run
		repeat (5) @(posedge clk);
		#2;
		i_flash.log_q.delete();
		deadline = cycle_cnt + 40 * (n_instr + exp_addr.size()) + 200;
		rst_n = 1'b1;
		for (i = 0; i < exp_addr.size(); i++) begin
			while (i_flash.log_q.size() <= i) begin
				@(negedge clk);
				check_flash_bus(name);
			end
			compare_addr($sformatf("%s, read %0d", name, i), exp_addr[i], i_flash.log_q[i]);
			check_level($sformatf("%s, q at read %0d", name, i), exp_q[i], q);
		end
		@(posedge rom_cs_n);
		check_flash_bus(name);
		repeat (150) begin   // Quiet window after IDL
			@(negedge clk);
			check_level({name, ", cs_n after IDL"}, 1'b1, rom_cs_n);
			if (i_flash.log_q.size() != exp_addr.size())
				stop_with_failure({name, ": the DUT read flash again after IDL"});
		end
		check_level({name, ", final q"}, exp_final_q, q);
		deadline = 0;
	endtask

	initial begin
		data_t prog [$];
		int k;
		rst_n = 1'b0;
		ef_n = 4'b1111;
		deadline = 0;
		seed = 89;
		prog = '{
			8'h7B, 8'hF8, 8'h80, 8'hB2, 8'hF8, 8'h10, 8'hA2, 8'hE2,   // SEQ, R2 = 8010, SEX 2
			8'hF8, 8'h5A, 8'h52, 8'hF8, 8'h00, 8'h02, 8'h3A, 8'h11,   // RAM store and load back
			8'h00, 8'hFC, 8'hA6, 8'h33, 8'h16, 8'h00, 8'h32, 8'h19,   // ADI carry, BDF, BZ
			8'h00, 8'h7A, 8'hF8, 8'h33, 8'hFF, 8'h34, 8'h3B, 8'h21,   // REQ, SMI borrow
			8'h00, 8'hFD, 8'h01, 8'h3B, 8'h26, 8'h00, 8'hF6, 8'hF6,   // SDI, two SHR
			8'h33, 8'h2B, 8'h00, 8'h7B, 8'hF8, 8'hC3, 8'hFE, 8'h52,
			8'hF8, 8'h0F, 8'hF2, 8'hF3, 8'hF1, 8'hF7, 8'h3A, 8'h00,   // Logic ops then SM
			8'h3B, 8'h00, 8'h42, 8'h52, 8'hF0, 8'hF4, 8'h72, 8'h82,   // LDA, LDX, ADD, LDXA
			8'hFB, 8'h12, 8'h3A, 8'h00, 8'h3B, 8'h00, 8'h31, 8'h49,   // XRI keeps ADD carry for BNF
			8'h00, 8'hF8, 8'h70, 8'hA3, 8'hF8, 8'h00, 8'hB3, 8'h53,   // Store below 8000h
			8'h23, 8'h13, 8'h13, 8'h83, 8'hFF, 8'h71, 8'h3A, 8'h00,
			8'h34, 8'h5B, 8'h15, 8'h35, 8'h5E, 8'h15, 8'h3E, 8'h61,   // Flag branches
			8'h15, 8'h37, 8'h64, 8'h15, 8'hF8, 8'h6B, 8'hA4, 8'hF8,
			8'h00, 8'hB4, 8'hD4, 8'h7A, 8'h30, 8'h6F, 8'h00, 8'h38,   // SEP 4, BR, SKP
			8'h00, 8'h00
		};
		for (k = 0; k < 256; k++) begin
			if (k < prog.size())
				model_img[k] = prog[k];
			else
				model_img[k] = data_t'(k) ^ 8'hA5;   // Never fetched
		end
		i_flash.image = model_img;
		run_program("fixed flags", 4'b0110);
		run_program("random flags", nibble_t'($random(seed)));
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== design/cpu_alu.sv ====
`include "cpu_defines.svh"

module cpu_alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::data_t d,
	input  cpu_pkg::data_t b,
	input  logic df,
	input  logic [2:0] cond_sel,
	input  logic cond_inv,
	input  logic q,
	input  cpu_pkg::nibble_t ef,
	output cpu_pkg::data_t result,
	output logic df_out,
	output logic take_branch
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W:0] sum;   // Carry in the top bit
	logic cond;

	always_comb begin
		result = b;
		df_out = df;
		sum = '0;
		case (op)
			ALU_OR: result = d | b;
			ALU_AND: result = d & b;
			ALU_XOR: result = d ^ b;
			ALU_ADD: begin
				sum = {1'b0, d} + {1'b0, b};
				{df_out, result} = sum;
			end
			ALU_SD: begin
				sum = {1'b0, b} + {1'b0, ~d} + 1'b1;   // DF set when no borrow
				{df_out, result} = sum;
			end
			ALU_SM: begin
				sum = {1'b0, d} + {1'b0, ~b} + 1'b1;
				{df_out, result} = sum;
			end
			ALU_SHR: begin
				df_out = d[0];
				result = {1'b0, d[7:1]};
			end
			ALU_SHL: begin
				df_out = d[7];
				result = {d[6:0], 1'b0};
			end
			default: result = b;
		endcase
	end

	always_comb begin
		case (cond_sel)
			3'd0: cond = 1'b1;
			3'd1: cond = q;
			3'd2: cond = (d == '0);
			3'd3: cond = df;
			default: cond = ef[cond_sel[1:0]];   // EF1..EF4
		endcase
	end

	assign take_branch = cond ^ cond_inv;

endmodule

// ==== design/cpu_core.sv ====
`include "cpu_defines.svh"

module cpu_core (
	input  logic clk,
	input  logic rst_n,
	input  cpu_pkg::nibble_t ef_n,
	output logic q,
	mem_if.core mem
);
	import cpu_pkg::*;

	addr_t regs [16];
	data_t d;
	logic df;
	data_t b;
	data_t ir;
	reg_sel_t x;
	reg_sel_t p;
	nibble_t ef_meta;
	nibble_t ef;
	core_state_t state;
	logic ld_ir;      // Pending read fills the instruction latch
	logic ld_b;       // Pending read fills B, else D
	logic b_ready;    // Second execute pass, operand sits in B
	logic req_start;
	logic req_write;
	addr_t req_addr;

	op_group_t grp;
	reg_sel_t n;
	alu_op_t alu_op;
	logic alu_shift;
	data_t alu_result;
	logic alu_df;
	logic take_branch;

	assign grp = op_group_t'(ir[7:4]);
	assign n = ir[3:0];

	assign mem.start = req_start;
	assign mem.write = req_write;
	assign mem.addr = req_addr;
	assign mem.wdata = d;   // D does not change while a store is pending

	always_comb begin
		alu_op = ALU_PASS;   // LDX, LDXA, LDI
		if (grp == GRP_ALU) begin
			case (n[2:0])
				3'd1: alu_op = ALU_OR;
				3'd2: alu_op = ALU_AND;
				3'd3: alu_op = ALU_XOR;
				3'd4: alu_op = ALU_ADD;
				3'd5: alu_op = ALU_SD;
				3'd6: alu_op = n[3] ? ALU_SHL : ALU_SHR;
				3'd7: alu_op = ALU_SM;
				default: alu_op = ALU_PASS;
			endcase
		end
	end

	assign alu_shift = (alu_op == ALU_SHR) || (alu_op == ALU_SHL);

	cpu_alu i_alu (
		.op          (alu_op),
		.d           (d),
		.b           (b),
		.df          (df),
		.cond_sel    (ir[2:0]),
		.cond_inv    (ir[3]),
		.q           (q),
		.ef          (ef),
		.result      (alu_result),
		.df_out      (alu_df),
		.take_branch (take_branch)
	);

	task automatic issue_access(input addr_t a, input logic wr, input logic to_b);
		req_start <= 1'b1;
		req_write <= wr;
		req_addr <= a;
		ld_ir <= 1'b0;
		ld_b <= to_b;
		state <= ST_MEM_WAIT;
	endtask

	always_ff @(posedge clk) begin
		ef_meta <= ~ef_n;   // Two-flop sync, flags become active high
		ef <= ef_meta;
		req_start <= 1'b0;
		if (!rst_n) begin
			state <= ST_FETCH;
			regs[0] <= `CPU_RESET_PC;
			x <= '0;
			p <= '0;
			d <= '0;
			df <= 1'b0;
			q <= 1'b0;
			req_write <= 1'b0;
			ld_ir <= 1'b0;
			ld_b <= 1'b0;
			b_ready <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					issue_access(regs[p], 1'b0, 1'b0);
					ld_ir <= 1'b1;
					regs[p] <= regs[p] + 1'b1;
				end
				ST_MEM_WAIT: begin
					if (mem.done) begin
						if (req_write) begin
							state <= ST_FETCH;
						end else if (ld_ir) begin
							ir <= mem.rdata;
							b_ready <= 1'b0;
							state <= ST_EXEC;
						end else if (ld_b) begin
							b <= mem.rdata;
							b_ready <= 1'b1;
							state <= ST_EXEC;
						end else begin
							d <= mem.rdata;
							state <= ST_FETCH;
						end
					end
				end
				ST_EXEC: begin
					state <= ST_FETCH;
					case (grp)
						GRP_IDL_LDN: begin
							if (n == 4'h0)
								state <= ST_IDLE;
							else
								issue_access(regs[n], 1'b0, 1'b0);
						end
						GRP_INC: regs[n] <= regs[n] + 1'b1;
						GRP_DEC: regs[n] <= regs[n] - 1'b1;
						GRP_SBR: begin
							if (b_ready)
								regs[p][7:0] <= b;   // Target stays in the operand's page
							else if (take_branch)
								issue_access(regs[p], 1'b0, 1'b1);
							else
								regs[p] <= regs[p] + 1'b1;   // Skip the operand
						end
						GRP_LDA: begin
							issue_access(regs[n], 1'b0, 1'b0);
							regs[n] <= regs[n] + 1'b1;
						end
						GRP_STR: issue_access(regs[n], 1'b1, 1'b0);
						GRP_CTRL, GRP_ALU: begin
							if (ir == 8'h7A) begin
								q <= 1'b0;
							end else if (ir == 8'h7B) begin
								q <= 1'b1;
							end else if (grp == GRP_ALU || n == 4'h2) begin
								if (b_ready || alu_shift) begin
									d <= alu_result;
									df <= alu_df;
								end else if (n[3]) begin
									issue_access(regs[p], 1'b0, 1'b1);   // Immediate form
									regs[p] <= regs[p] + 1'b1;
								end else begin
									issue_access(regs[x], 1'b0, 1'b1);
									if (grp == GRP_CTRL)
										regs[x] <= regs[x] + 1'b1;   // LDXA
								end
							end
						end
						GRP_GLO: d <= regs[n][7:0];
						GRP_GHI: d <= regs[n][15:8];
						GRP_PLO: regs[n][7:0] <= d;
						GRP_PHI: regs[n][15:8] <= d;
						GRP_SEP: p <= n;
						GRP_SEX: x <= n;
						default: ;   // I/O and long branches act as NOP
					endcase
				end
				default: ;   // Idle until reset
			endcase
		end
	end

endmodule

// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// Internal RAM in bytes, mapped at 8000h and up
`define CPU_RAM_SIZE 128

// R0 value after reset
`define CPU_RESET_PC 16'h0000

// Continuous-read mode bits sent after the address
`define QSPI_MODE_HI 4'b1010
`define QSPI_MODE_LO 4'b0101

`endif

// ==== design/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_DATA_W-1:0] data_t;
	typedef logic [3:0] nibble_t;
	typedef logic [3:0] reg_sel_t;

	// High nibble of the opcode
	typedef enum logic [3:0] {
		GRP_IDL_LDN, GRP_INC, GRP_DEC, GRP_SBR,
		GRP_LDA, GRP_STR, GRP_IO, GRP_CTRL,
		GRP_GLO, GRP_GHI, GRP_PLO, GRP_PHI,
		GRP_LBR, GRP_SEP, GRP_SEX, GRP_ALU
	} op_group_t;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEM_WAIT,
		ST_IDLE
	} core_state_t;

	typedef enum logic [3:0] {
		ALU_PASS, ALU_OR, ALU_AND, ALU_XOR, ALU_ADD,
		ALU_SD, ALU_SHR, ALU_SM, ALU_SHL
	} alu_op_t;

endpackage

// ==== design/cpu_top.sv ====
module cpu_top (
	input  logic clk,
	input  logic rst_n,
	input  cpu_pkg::nibble_t ef_n,
	input  cpu_pkg::nibble_t rom_din,
	output logic q,
	output logic rom_cs_n,
	output logic rom_sclk,
	output cpu_pkg::nibble_t rom_dout,
	output cpu_pkg::nibble_t rom_oe_n
);

	mem_if i_mem_bus ();

	cpu_core i_core (
		.clk   (clk),
		.rst_n (rst_n),
		.ef_n  (ef_n),
		.q     (q),
		.mem   (i_mem_bus.core)
	);

	mem_ctrl i_mem_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.rom_din  (rom_din),
		.rom_cs_n (rom_cs_n),
		.rom_sclk (rom_sclk),
		.rom_dout (rom_dout),
		.rom_oe_n (rom_oe_n),
		.mem      (i_mem_bus.mem)
	);

endmodule

// ==== design/mem_ctrl.sv ====
`include "cpu_defines.svh"

module mem_ctrl #(
	parameter int RAM_SIZE = `CPU_RAM_SIZE
) (
	input  logic clk,
	input  logic rst_n,
	input  cpu_pkg::nibble_t rom_din,
	output logic rom_cs_n,
	output logic rom_sclk,
	output cpu_pkg::nibble_t rom_dout,
	output cpu_pkg::nibble_t rom_oe_n,
	mem_if.mem mem
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(RAM_SIZE);

	data_t ram [RAM_SIZE];
	data_t ram_rdata;
	data_t rom_data;
	logic is_ram;
	logic rom_start;
	logic rom_done;
	logic local_done;   // RAM access or dropped flash write

	assign is_ram = mem.addr[`CPU_ADDR_W-1];
	assign rom_start = mem.start && !is_ram && !mem.write;

	always_ff @(posedge clk) begin
		if (mem.start && is_ram) begin
			if (mem.write)
				ram[mem.addr[IDX_W-1:0]] <= mem.wdata;
			ram_rdata <= ram[mem.addr[IDX_W-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			local_done <= 1'b0;
		else
			local_done <= mem.start && (is_ram || mem.write);
	end

	assign mem.done = local_done || rom_done;
	assign mem.rdata = local_done ? ram_rdata : rom_data;

	qspi_rom_reader i_rom_reader (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (rom_start),
		.addr     (mem.addr),
		.rom_din  (rom_din),
		.rom_cs_n (rom_cs_n),
		.rom_sclk (rom_sclk),
		.rom_dout (rom_dout),
		.rom_oe_n (rom_oe_n),
		.data     (rom_data),
		.done     (rom_done)
	);

endmodule

// ==== design/mem_if.sv ====
interface mem_if;
	import cpu_pkg::*;

	logic start;   // One-cycle request strobe
	logic write;
	addr_t addr;
	data_t wdata;
	data_t rdata;
	logic done;    // One-cycle completion, rdata valid here

	modport core (output start, output write, output addr, output wdata,
		input rdata, input done);

	modport mem (input start, input write, input addr, input wdata,
		output rdata, output done);

endinterface

// ==== design/qspi_rom_reader.sv ====
`include "cpu_defines.svh"

module qspi_rom_reader (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  cpu_pkg::addr_t addr,
	input  cpu_pkg::nibble_t rom_din,
	output logic rom_cs_n,
	output logic rom_sclk,
	output cpu_pkg::nibble_t rom_dout,
	output cpu_pkg::nibble_t rom_oe_n,
	output cpu_pkg::data_t data,
	output logic done
);
	import cpu_pkg::*;

	// 0 when idle; odd counts raise SCLK, even counts lower it
	logic [4:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			rom_cs_n <= 1'b1;
			rom_sclk <= 1'b0;
			rom_dout <= '0;
			rom_oe_n <= 4'b1111;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (cnt == '0) begin
				if (start) begin
					cnt <= 5'd1;
					rom_cs_n <= 1'b0;
					rom_sclk <= 1'b0;
					rom_oe_n <= 4'b0000;
					rom_dout <= '0;   // First of two zero nibbles
				end
			end else begin
				cnt <= (cnt == 5'd28) ? 5'd0 : cnt + 5'd1;
				rom_sclk <= cnt[0];
				case (cnt)
					5'd2: rom_dout <= '0;
					5'd4: rom_dout <= addr[15:12];
					5'd6: rom_dout <= addr[11:8];
					5'd8: rom_dout <= addr[7:4];
					5'd10: rom_dout <= addr[3:0];
					5'd12: rom_dout <= `QSPI_MODE_HI;
					5'd14: rom_dout <= `QSPI_MODE_LO;
					5'd16: begin
						rom_oe_n <= 4'b1111;   // Turnaround, four dummy clocks follow
						rom_dout <= '0;
					end
					5'd28: begin
						rom_cs_n <= 1'b1;
						done <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Sampled as SCLK rises
	always_ff @(posedge clk) begin
		if (cnt == 5'd25)
			data[7:4] <= rom_din;
		if (cnt == 5'd27)
			data[3:0] <= rom_din;
	end

endmodule

// ==== list.f ====
+incdir+design
+incdir+bench
design/cpu_pkg.sv
design/mem_if.sv
design/cpu_alu.sv
design/qspi_rom_reader.sv
design/mem_ctrl.sv
design/cpu_core.sv
design/cpu_top.sv
bench/flash_model.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }
